//--- sources.f
+incdir+include
logic/cpu_pkg.sv
logic/pipe_bus.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_stage.sv
logic/register_bank.sv
logic/cpu.sv
tb/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module cpu_tb -Mdir obj_dir \
    && ./obj_dir/Vcpu_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

//--- tb/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_tb;
    localparam int NUM_PROGRAMS = 5;
    localparam int MAX_WORDS    = 16;
    localparam int ROM_WORDS    = 1 << `CPU_ROM_AW;
    localparam int PERIOD       = 4;
    localparam int QUIET_CYCLES = 8;
    localparam int NO_WB        = -1;  // Entry that never writes back

    // RV32I funct fields
    localparam int F3_ADD = 0;
    localparam int F3_SLT = 2;
    localparam int F3_XOR = 4;
    localparam int F3_OR  = 6;
    localparam int F3_AND = 7;
    localparam int F7_SUB = 32;
    localparam int F3_BEQ = 0;
    localparam int F3_BNE = 1;

    logic                   clock_real;
    logic                   rst_n;
    logic [31:0]            rom_data;
    logic [`CPU_ROM_AW-1:0] rom_address;
    logic                   wb_valid;
    logic [4:0]             wb_rd;
    logic [`CPU_XLEN-1:0]   wb_value;
    logic [5:0]             led;

    logic [31:0] rom [ROM_WORDS];

    // Programs and their write-backs in retire order
    logic [31:0]          prog_word   [NUM_PROGRAMS][MAX_WORDS];
    int                   prog_len    [NUM_PROGRAMS];
    logic [4:0]           exp_rd      [NUM_PROGRAMS][MAX_WORDS];
    logic [`CPU_XLEN-1:0] exp_value   [NUM_PROGRAMS][MAX_WORDS];
    logic                 exp_is_load [NUM_PROGRAMS][MAX_WORDS];
    int                   exp_len     [NUM_PROGRAMS];

    int value_errors;
    int other_errors;

    cpu uut (
        .clock_real  (clock_real),
        .rst_n       (rst_n),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .led         (led)
    );

    assign rom_data = rom[rom_address];  // Combinational ROM

    initial clock_real = 1'b0;
    always #(PERIOD / 2) clock_real = ~clock_real;

    // Instruction encoders
    function automatic logic [31:0] alu_rr(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] br(input int f3, input int rs1, input int rs2,
                                       input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    task automatic add_entry(input int p, input logic [31:0] word, input int rd,
                             input logic [`CPU_XLEN-1:0] value);
        prog_word[p][prog_len[p]] = word;
        prog_len[p]++;
        if (rd != NO_WB) begin
            exp_rd[p][exp_len[p]]      = rd[4:0];
            exp_value[p][exp_len[p]]   = value;
            exp_is_load[p][exp_len[p]] = (word[6:0] == 7'b0000011);  // LED shows the address
            exp_len[p]++;
        end
    endtask

    task automatic build_table();
        // ALU operations, ADDI and LUI
        add_entry(0, addi(1, 0, 100), 1, 32'h0000_0064);
        add_entry(0, addi(2, 0, -7), 2, 32'hffff_fff9);
        add_entry(0, lui(3, 'h12345), 3, 32'h1234_5000);
        add_entry(0, alu_rr(0, F3_ADD, 4, 1, 2), 4, 32'h0000_005d);
        add_entry(0, alu_rr(F7_SUB, F3_ADD, 5, 1, 2), 5, 32'h0000_006b);
        add_entry(0, alu_rr(0, F3_AND, 6, 1, 2), 6, 32'h0000_0060);
        add_entry(0, alu_rr(0, F3_OR, 7, 1, 2), 7, 32'hffff_fffd);
        add_entry(0, alu_rr(0, F3_XOR, 8, 1, 2), 8, 32'hffff_ff9d);
        add_entry(0, alu_rr(0, F3_SLT, 9, 2, 1), 9, 32'h0000_0001);
        add_entry(0, alu_rr(0, F3_SLT, 10, 1, 2), 10, 32'h0000_0000);
        add_entry(0, alu_rr(0, F3_ADD, 11, 3, 1), 11, 32'h1234_5064);
        add_entry(0, br(F3_BEQ, 0, 0, 0), NO_WB, 32'h0);  // Branch to self
        // Forwarding at distance 1, 2 and 3
        add_entry(1, addi(1, 0, 5), 1, 32'd5);
        add_entry(1, addi(2, 1, 3), 2, 32'd8);
        add_entry(1, alu_rr(0, F3_ADD, 3, 1, 2), 3, 32'd13);
        add_entry(1, alu_rr(F7_SUB, F3_ADD, 4, 3, 1), 4, 32'd8);
        add_entry(1, alu_rr(0, F3_ADD, 5, 2, 4), 5, 32'd16);
        add_entry(1, alu_rr(0, F3_ADD, 6, 3, 3), 6, 32'd26);
        add_entry(1, addi(1, 1, 1), 1, 32'd6);
        add_entry(1, alu_rr(0, F3_ADD, 7, 1, 6), 7, 32'd32);
        add_entry(1, addi(8, 0, 1), 8, 32'd1);
        add_entry(1, addi(8, 8, 2), 8, 32'd3);
        add_entry(1, alu_rr(0, F3_ADD, 9, 8, 8), 9, 32'd6);  // Younger x8 must win
        add_entry(1, br(F3_BEQ, 0, 0, 0), NO_WB, 32'h0);
        // Store, load and load-use
        add_entry(2, addi(1, 0, 'h20), 1, 32'h0000_0020);
        add_entry(2, addi(2, 0, 'h155), 2, 32'h0000_0155);
        add_entry(2, sw(2, 1, 4), NO_WB, 32'h0);
        add_entry(2, lw(3, 1, 4), 3, 32'h0000_0155);
        add_entry(2, alu_rr(0, F3_ADD, 4, 3, 1), 4, 32'h0000_0175);
        add_entry(2, addi(5, 0, -1), 5, 32'hffff_ffff);
        add_entry(2, sw(5, 1, 0), NO_WB, 32'h0);
        add_entry(2, lw(6, 1, 0), 6, 32'hffff_ffff);
        add_entry(2, alu_rr(F7_SUB, F3_ADD, 7, 2, 6), 7, 32'h0000_0156);
        add_entry(2, lw(8, 1, 4), 8, 32'h0000_0155);
        add_entry(2, addi(9, 8, 1), 9, 32'h0000_0156);
        add_entry(2, br(F3_BEQ, 0, 0, 0), NO_WB, 32'h0);
        // Taken and not-taken branches
        add_entry(3, addi(1, 0, 3), 1, 32'd3);
        add_entry(3, addi(2, 0, 3), 2, 32'd3);
        add_entry(3, br(F3_BEQ, 1, 2, 12), NO_WB, 32'h0);  // Taken to pc 20
        add_entry(3, addi(3, 0, 'h11), NO_WB, 32'h0);
        add_entry(3, addi(4, 0, 'h22), NO_WB, 32'h0);
        add_entry(3, addi(5, 0, 'h33), 5, 32'h0000_0033);
        add_entry(3, br(F3_BNE, 1, 2, 8), NO_WB, 32'h0);  // Not taken
        add_entry(3, addi(6, 0, 'h44), 6, 32'h0000_0044);
        add_entry(3, br(F3_BNE, 5, 1, 12), NO_WB, 32'h0);  // Taken to pc 44
        add_entry(3, addi(7, 0, 'h55), NO_WB, 32'h0);
        add_entry(3, addi(8, 0, 'h66), NO_WB, 32'h0);
        add_entry(3, br(F3_BEQ, 1, 6, 8), NO_WB, 32'h0);
        add_entry(3, addi(9, 6, 1), 9, 32'h0000_0045);
        add_entry(3, br(F3_BEQ, 0, 0, 0), NO_WB, 32'h0);
        // Register zero
        add_entry(4, addi(0, 0, 'h7f), 0, 32'h0000_007f);
        add_entry(4, alu_rr(0, F3_ADD, 1, 0, 0), 1, 32'h0);
        add_entry(4, lui(0, 'habcde), 0, 32'habcd_e000);
        add_entry(4, addi(2, 0, 5), 2, 32'd5);
        add_entry(4, alu_rr(0, F3_ADD, 3, 0, 2), 3, 32'd5);
        add_entry(4, addi(0, 0, 1), 0, 32'd1);
        add_entry(4, addi(4, 0, 9), 4, 32'd9);
        add_entry(4, br(F3_BEQ, 0, 0, 0), NO_WB, 32'h0);
    endtask

    task automatic load_rom(input int p);
        for (int i = 0; i < ROM_WORDS; i++) begin
            if (i < prog_len[p])
                rom[i] = prog_word[p][i];
            else  // Unused opcode 7'h7f, decodes as a nop
                rom[i] = {i[`CPU_ROM_AW-1:0], {(25 - `CPU_ROM_AW){1'b0}}, 7'h7f};
        end
    endtask

    // Heartbeat LED toggles every cycle out of reset
    task automatic check_heartbeat(input int p, input logic expected);
        if (led[5] !== expected) begin
            $display("Error: program %0d led[5] = %h, expected %h", p, led[5], expected);
            value_errors++;
        end
    endtask

    task automatic run_program(input int p);
        int         got;
        logic [5:0] prev_led;
        load_rom(p);
        rst_n = 1'b0;
        repeat (4) @(posedge clock_real);
        #1 rst_n = 1'b1;
        got      = 0;
        prev_led = led;
        check_heartbeat(p, 1'b0);
        while (got < exp_len[p]) begin
            @(posedge clock_real);
            #1;
            check_heartbeat(p, ~prev_led[5]);
            if (wb_valid === 1'b1) begin
                if (wb_rd !== exp_rd[p][got]) begin
                    $display("Error: program %0d write-back %0d wb_rd = %h, expected %h",
                             p, got, wb_rd, exp_rd[p][got]);
                    value_errors++;
                end
                if (wb_value !== exp_value[p][got]) begin
                    $display("Error: program %0d write-back %0d wb_value = %h, expected %h",
                             p, got, wb_value, exp_value[p][got]);
                    value_errors++;
                end
                // One cycle earlier the result sat in the execute/memory register
                if (!exp_is_load[p][got] && prev_led[4:0] !== exp_value[p][got][4:0]) begin
                    $display({"Error: program %0d write-back %0d led[4:0] = %h",
                              " in the cycle before, expected %h"},
                             p, got, prev_led[4:0], exp_value[p][got][4:0]);
                    value_errors++;
                end
                got++;
            end
            prev_led = led;
        end
        // Halt loop must stay silent
        repeat (QUIET_CYCLES) begin
            @(posedge clock_real);
            #1;
            check_heartbeat(p, ~prev_led[5]);
            prev_led = led;
            if (wb_valid !== 1'b0) begin
                $display("Error: program %0d wrote back to x%0d after its last instruction",
                         p, wb_rd);
                other_errors++;
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        value_errors = 0;
        other_errors = 0;
        build_table();
        for (int p = 0; p < NUM_PROGRAMS; p++)
            run_program(p);
        $display("Checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog, 40 cycles for each table word
    initial begin
        #(40 * MAX_WORDS * NUM_PROGRAMS * PERIOD);
        $display("Timeout: programs still running after %0d cycles, %0d errors so far",
                 40 * MAX_WORDS * NUM_PROGRAMS, value_errors + other_errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu (
    input  logic                   clock_real,
    input  logic                   rst_n,
    input  logic [31:0]            rom_data,
    output logic [`CPU_ROM_AW-1:0] rom_address,
    output logic                   wb_valid,
    output logic [4:0]             wb_rd,
    output logic [`CPU_XLEN-1:0]   wb_value,
    output logic [5:0]             led
);
    logic [`CPU_XLEN-1:0] if_pc, if_instr;
    logic                 if_valid;
    logic                 stall;
    logic                 redirect;
    logic [`CPU_XLEN-1:0] redirect_pc;
    logic [4:0]           rb_read_address1, rb_read_address2;
    logic [`CPU_XLEN-1:0] rb_value1, rb_value2;
    logic                 wb_en;
    logic                 heartbeat;

    id_ex_bus  id_ex ();
    ex_mem_bus ex_mem ();

    fetch u_fetch (
        .clock_real  (clock_real),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .pc          (if_pc),
        .instr       (if_instr),
        .instr_valid (if_valid)
    );

    decode u_decode (
        .clock_real  (clock_real),
        .rst_n       (rst_n),
        .pc          (if_pc),
        .instr       (if_instr),
        .instr_valid (if_valid),
        .redirect    (redirect),
        .rs1_addr    (rb_read_address1),
        .rs2_addr    (rb_read_address2),
        .rs1_value   (rb_value1),
        .rs2_value   (rb_value2),
        .stall       (stall),
        .ex_mem      (ex_mem.hazard),
        .id_ex       (id_ex.stage_out)
    );

    execute u_execute (
        .clock_real  (clock_real),
        .rst_n       (rst_n),
        .id_ex       (id_ex.stage_in),
        .ex_mem      (ex_mem.stage_out),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    mem_stage u_mem_stage (
        .clock_real (clock_real),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem.stage_in),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value)
    );

    register_bank u_register_bank (
        .clock_real    (clock_real),
        .rst_n         (rst_n),
        .write_enable  (wb_en),
        .write_address (wb_rd),
        .write_value   (wb_value),
        .read_address1 (rb_read_address1),
        .read_address2 (rb_read_address2),
        .value1        (rb_value1),
        .value2        (rb_value2)
    );

    assign wb_valid = wb_en;

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n)
            heartbeat <= 1'b0;
        else
            heartbeat <= ~heartbeat;  // Toggles every cycle
    end

    assign led[4:0] = ex_mem.result[4:0];
    assign led[5]   = heartbeat;

endmodule

//--- logic/register_bank.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module register_bank (
    input  logic                 clock_real,
    input  logic                 rst_n,
    input  logic                 write_enable,
    input  logic [4:0]           write_address,
    input  logic [`CPU_XLEN-1:0] write_value,
    input  logic [4:0]           read_address1,
    input  logic [4:0]           read_address2,
    output logic [`CPU_XLEN-1:0] value1,
    output logic [`CPU_XLEN-1:0] value2
);
    logic [`CPU_XLEN-1:0] regs [32];

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_enable && write_address != 5'd0) begin
            regs[write_address] <= write_value;
        end
    end

    // x0 reads zero, a same-cycle write is passed through
    assign value1 = (read_address1 == 5'd0) ? '0 :
                    (write_enable && write_address == read_address1) ? write_value :
                    regs[read_address1];
    assign value2 = (read_address2 == 5'd0) ? '0 :
                    (write_enable && write_address == read_address2) ? write_value :
                    regs[read_address2];

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module mem_stage (
    input  logic                 clock_real,
    input  logic                 rst_n,
    ex_mem_bus.stage_in          ex_mem,
    output logic                 wb_en,
    output logic [4:0]           wb_rd,
    output logic [`CPU_XLEN-1:0] wb_value
);
    localparam int RAM_AW = $clog2(`CPU_RAM_WORDS);

    logic [`CPU_XLEN-1:0] ram [`CPU_RAM_WORDS];
    logic [RAM_AW-1:0]    ram_index;
    logic [`CPU_XLEN-1:0] load_word;

    // Word index from the byte address, upper bits ignored
    assign ram_index = ex_mem.result[RAM_AW+1:2];
    assign load_word = ram[ram_index];  // Asynchronous read

    always_ff @(posedge clock_real) begin
        if (ex_mem.valid && ex_mem.mem_write)
            ram[ram_index] <= ex_mem.store_data;
    end

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n)
            wb_en <= 1'b0;
        else
            wb_en <= ex_mem.valid && ex_mem.reg_write;
    end

    // Write-back select folded into the memory/write-back register
    always_ff @(posedge clock_real) begin
        wb_rd    <= ex_mem.rd;
        wb_value <= ex_mem.mem_read ? load_word : ex_mem.result;
    end

endmodule

//--- logic/execute.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module execute import cpu_pkg::*; (
    input  logic                 clock_real,
    input  logic                 rst_n,
    id_ex_bus.stage_in           id_ex,
    ex_mem_bus.stage_out         ex_mem,
    input  logic                 wb_en,
    input  logic [4:0]           wb_rd,
    input  logic [`CPU_XLEN-1:0] wb_value,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] redirect_pc
);
    logic [`CPU_XLEN-1:0] op_a, op_b, alu_b;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 operands_equal;
    logic                 taken;

    // Younger producer first, x0 never forwarded
    function automatic logic [`CPU_XLEN-1:0] forward(input logic [4:0] rs,
                                                      input logic [`CPU_XLEN-1:0] bus_value);
        logic from_mem, from_wb;
        from_mem = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read &&
                   (ex_mem.rd == rs) && (rs != 5'd0);
        from_wb  = wb_en && (wb_rd == rs) && (rs != 5'd0);
        if (from_mem)
            return ex_mem.result;
        else if (from_wb)
            return wb_value;
        return bus_value;
    endfunction

    assign op_a  = forward(id_ex.rs1, id_ex.rs1_value);
    assign op_b  = forward(id_ex.rs2, id_ex.rs2_value);
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + alu_b;
            ALU_SUB:    alu_result = op_a - alu_b;
            ALU_AND:    alu_result = op_a & alu_b;
            ALU_OR:     alu_result = op_a | alu_b;
            ALU_XOR:    alu_result = op_a ^ alu_b;
            ALU_SLT:    alu_result = {{(`CPU_XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch resolution on forwarded operands
    assign operands_equal = (op_a == op_b);
    assign taken = id_ex.valid && ((id_ex.branch == BR_EQ && operands_equal) ||
                                   (id_ex.branch == BR_NE && !operands_equal));
    assign redirect    = taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.valid     <= id_ex.valid && !taken;
            ex_mem.reg_write <= id_ex.reg_write;
            ex_mem.mem_read  <= id_ex.mem_read;
            ex_mem.mem_write <= id_ex.mem_write;
        end
    end

    always_ff @(posedge clock_real) begin
        ex_mem.result     <= alu_result;
        ex_mem.store_data <= op_b;  // Forwarded rs2 for SW
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

//--- logic/decode.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module decode import cpu_pkg::*; (
    input  logic                 clock_real,
    input  logic                 rst_n,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] instr,
    input  logic                 instr_valid,
    input  logic                 redirect,
    output logic [4:0]           rs1_addr,
    output logic [4:0]           rs2_addr,
    input  logic [`CPU_XLEN-1:0] rs1_value,
    input  logic [`CPU_XLEN-1:0] rs2_value,
    output logic                 stall,
    ex_mem_bus.hazard            ex_mem,
    id_ex_bus.stage_out          id_ex
);
    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CPU_XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
    logic [`CPU_XLEN-1:0] dec_imm;
    logic                 dec_use_imm;
    alu_op_e              dec_alu_op;
    branch_e              dec_branch;
    logic                 dec_reg_write, dec_mem_read, dec_mem_write;
    logic                 uses_rs1, uses_rs2;
    logic                 load_in_ex;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec_imm       = imm_i;
        dec_use_imm   = 1'b0;
        dec_alu_op    = ALU_ADD;  // Also the address adder for LW/SW
        dec_branch    = BR_NONE;
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec_reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec_alu_op = ALU_SLT;
                    3'b100:  dec_alu_op = ALU_XOR;
                    3'b110:  dec_alu_op = ALU_OR;
                    3'b111:  dec_alu_op = ALU_AND;
                    default: dec_reg_write = 1'b0;  // Unsupported, acts as a nop
                endcase
            end
            OPC_OP_IMM: begin
                uses_rs1      = 1'b1;
                dec_use_imm   = 1'b1;
                dec_reg_write = (funct3 == 3'b000);  // ADDI only
            end
            OPC_LUI: begin
                dec_imm       = imm_u;
                dec_use_imm   = 1'b1;
                dec_alu_op    = ALU_PASS_B;
                dec_reg_write = 1'b1;
            end
            OPC_LOAD: begin
                uses_rs1      = 1'b1;
                dec_use_imm   = 1'b1;
                dec_mem_read  = (funct3 == 3'b010);
                dec_reg_write = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec_imm       = imm_s;
                dec_use_imm   = 1'b1;
                dec_mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                dec_imm  = imm_b;
                if (funct3 == 3'b000)
                    dec_branch = BR_EQ;
                else if (funct3 == 3'b001)
                    dec_branch = BR_NE;
            end
            default: ;
        endcase
    end

    // Load sitting in execute, its data only shows up after the memory stage
    assign load_in_ex = id_ex.valid && id_ex.mem_read && (id_ex.rd != 5'd0);
    assign stall = instr_valid && load_in_ex &&
                   ((uses_rs1 && rs1_addr == id_ex.rd) || (uses_rs2 && rs2_addr == id_ex.rd));

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid     <= 1'b0;
            id_ex.branch    <= BR_NONE;
            id_ex.reg_write <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
        end else begin
            id_ex.valid     <= instr_valid && !stall && !redirect;  // Bubble or squash
            id_ex.branch    <= dec_branch;
            id_ex.reg_write <= dec_reg_write;
            id_ex.mem_read  <= dec_mem_read;
            id_ex.mem_write <= dec_mem_write;
        end
    end

    always_ff @(posedge clock_real) begin
        id_ex.pc        <= pc;
        id_ex.rs1_value <= rs1_value;
        id_ex.rs2_value <= rs2_value;
        id_ex.rs1       <= rs1_addr;
        id_ex.rs2       <= rs2_addr;
        id_ex.imm       <= dec_imm;
        id_ex.use_imm   <= dec_use_imm;
        id_ex.alu_op    <= dec_alu_op;
        id_ex.rd        <= instr[11:7];
    end

endmodule

//--- logic/fetch.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module fetch (
    input  logic                   clock_real,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   redirect,
    input  logic [`CPU_XLEN-1:0]   redirect_pc,
    input  logic [`CPU_XLEN-1:0]   rom_data,
    output logic [`CPU_ROM_AW-1:0] rom_address,
    output logic [`CPU_XLEN-1:0]   pc,
    output logic [`CPU_XLEN-1:0]   instr,
    output logic                   instr_valid
);
    logic [`CPU_XLEN-1:0] fetch_pc;  // Address currently on the ROM

    // ROM is word addressed
    assign rom_address = fetch_pc[`CPU_ROM_AW+1:2];

    always_ff @(posedge clock_real or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc    <= `CPU_RESET_PC;
            instr_valid <= 1'b0;
        end else if (redirect) begin
            fetch_pc    <= redirect_pc;
            instr_valid <= 1'b0;  // Drop the wrong-path word being fetched
        end else if (!stall) begin
            fetch_pc    <= fetch_pc + 4;
            instr_valid <= 1'b1;
        end
    end

    // Fetch/decode register payload, held during a stall
    always_ff @(posedge clock_real) begin
        if (!stall) begin
            pc    <= fetch_pc;
            instr <= rom_data;
        end
    end

endmodule

//--- logic/pipe_bus.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

// Decode to execute pipeline register contents
interface id_ex_bus import cpu_pkg::*; ();
    logic                 valid;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] rs1_value;
    logic [`CPU_XLEN-1:0] rs2_value;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [`CPU_XLEN-1:0] imm;
    logic                 use_imm;  // ALU operand b from imm
    alu_op_e              alu_op;
    branch_e              branch;
    logic [4:0]           rd;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;

    modport stage_out (output valid, pc, rs1_value, rs2_value, rs1, rs2, imm, use_imm,
                       alu_op, branch, rd, reg_write, mem_read, mem_write);
    modport stage_in (input valid, pc, rs1_value, rs2_value, rs1, rs2, imm, use_imm,
                      alu_op, branch, rd, reg_write, mem_read, mem_write);
endinterface

// Execute to memory pipeline register contents
interface ex_mem_bus ();
    logic                 valid;
    logic [`CPU_XLEN-1:0] result;      // ALU result or load/store address
    logic [`CPU_XLEN-1:0] store_data;
    logic [4:0]           rd;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;

    modport stage_out (output valid, result, store_data, rd, reg_write, mem_read, mem_write);
    modport stage_in (input valid, result, store_data, rd, reg_write, mem_read, mem_write);
    modport hazard (input valid, rd, mem_read);
endinterface

//--- logic/cpu_pkg.sv
package cpu_pkg;

    // RV32I major opcodes, subset used by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI, operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

endpackage

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and register width
`define CPU_XLEN 32

// Instruction ROM word address bits
`define CPU_ROM_AW 8

// Data RAM depth in 32-bit words
`define CPU_RAM_WORDS 64

`define CPU_RESET_PC 32'h0000_0000  // Byte address of first instruction

`endif
